/* include/load_unit_defines.svh */
// load unit parameters
// data path widths, cache address split and load buffer sizing

`ifndef LOAD_UNIT_DEFINES_SVH
`define LOAD_UNIT_DEFINES_SVH

// --------------------
// data path
// --------------------
// register width of the core
`define LU_XLEN 64
// byte offset inside one XLEN word
`define LU_OFFSET_W 3

// --------------------
// cache address split
// --------------------
`define LU_ADDR_W 32
// index covers the page offset
`define LU_INDEX_W 12
// tag is the rest of the address
`define LU_TAG_W 20

// --------------------
// ids and buffering
// --------------------
// scoreboard transaction id
`define LU_TRANS_ID_W 3
// outstanding loads, log2 gives the request id width
`define LU_NR_LDBUF 4
`define LU_LDBUF_ID_W 2

`endif

/* logic/load_unit_pkg.sv */
// load unit types
// opcodes, FSM states and the structs on the LSU and cache ports

`include "load_unit_defines.svh"

package load_unit_pkg;

  // load opcodes, signed and unsigned variants
  typedef enum logic [2:0] {
    LD,
    LW,
    LWU,
    LH,
    LHU,
    LB,
    LBU
  } load_op_e;

  // request FSM states
  typedef enum logic [2:0] {
    IDLE,
    WAIT_PAGE_OFFSET,
    WAIT_GNT,
    SEND_TAG,
    WAIT_FLUSH
  } load_state_e;

  // load request from the LSU queue
  typedef struct packed {
    logic [`LU_TRANS_ID_W-1:0] trans_id;
    logic [`LU_ADDR_W-1:0]     address;
    logic [`LU_XLEN/8-1:0]     be;
    load_op_e                  operation;
  } load_req_t;

  // request towards the data cache
  typedef struct packed {
    logic                      data_req;
    logic [`LU_INDEX_W-1:0]    address_index;
    logic [`LU_TAG_W-1:0]      address_tag;
    logic [`LU_LDBUF_ID_W-1:0] data_id;
    logic [`LU_XLEN/8-1:0]     data_be;
    logic [1:0]                data_size;
    logic                      tag_valid;
    logic                      kill_req;
  } dcache_req_t;

  // answer from the data cache
  typedef struct packed {
    logic                      data_gnt;
    logic                      data_rvalid;
    logic [`LU_LDBUF_ID_W-1:0] data_rid;
    logic [`LU_XLEN-1:0]       data_rdata;
  } dcache_rsp_t;

  // one outstanding load, kept until its response
  typedef struct packed {
    logic [`LU_TRANS_ID_W-1:0] trans_id;
    logic [`LU_OFFSET_W-1:0]   address_offset;
    load_op_e                  operation;
  } ldbuf_entry_t;

endpackage

/* logic/load_ctrl_fsm.sv */
// load request FSM
// issues index and tag cycles to the data cache, stalls on store page-offset hits

`timescale 1ns/1ps
`include "load_unit_defines.svh"

module load_ctrl_fsm (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  // request from the LSU queue
  input  logic                     valid_i,
  input  load_unit_pkg::load_req_t ld_req_i,
  // store unit address check
  input  logic                     page_offset_matches_i,
  // cache handshake
  input  logic                     data_gnt_i,
  // load buffer status
  input  logic                     ldbuf_full_i,
  output logic                     pop_ld_o,
  output logic                     data_req_o,
  output logic                     tag_valid_o,
  output logic                     kill_req_o,
  output logic [`LU_TAG_W-1:0]     addr_tag_o,
  output logic [1:0]               data_size_o,
  output logic                     ldbuf_w_o
);
  import load_unit_pkg::*;

  load_state_e state_d, state_q;
  logic accept_req;
  logic [`LU_TAG_W-1:0] tag_q;

  // transfer size in log2 bytes
  function automatic logic [1:0] op_size(load_op_e op);
    case (op)
      LD:       return 2'd3;
      LW, LWU:  return 2'd2;
      LH, LHU:  return 2'd1;
      default:  return 2'd0;
    endcase
  endfunction

  assign data_size_o = op_size(ld_req_i.operation);

  // a new load only goes out while a buffer slot is free
  assign accept_req = valid_i && !ldbuf_full_i;

  // --------------------
  // next state
  // --------------------
  always_comb begin : ctrl_comb
    state_d     = state_q;
    data_req_o  = 1'b0;
    tag_valid_o = 1'b0;
    kill_req_o  = 1'b0;
    pop_ld_o    = 1'b0;

    case (state_q)
      // SEND_TAG presents the tag and can start the next load right away
      IDLE, SEND_TAG: begin
        tag_valid_o = (state_q == SEND_TAG);
        state_d     = IDLE;
        if (accept_req) begin
          if (page_offset_matches_i) begin
            // a pending store hits the same page offset
            state_d = WAIT_PAGE_OFFSET;
          end else begin
            data_req_o = 1'b1;
            if (data_gnt_i) begin
              // tag goes out in the next cycle
              pop_ld_o = 1'b1;
              state_d  = SEND_TAG;
            end else begin
              state_d = WAIT_GNT;
            end
          end
        end
      end

      // wait for the store unit to drain the matching store
      WAIT_PAGE_OFFSET: begin
        if (!page_offset_matches_i) begin
          state_d = WAIT_GNT;
        end
      end

      // request stays up until the cache takes it
      WAIT_GNT: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          pop_ld_o = 1'b1;
          state_d  = SEND_TAG;
        end
      end

      // tag cycle of an outstanding request gets killed
      WAIT_FLUSH: begin
        tag_valid_o = 1'b1;
        kill_req_o  = 1'b1;
        state_d     = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase

    // flush wins over everything else
    if (flush_i) begin
      state_d = WAIT_FLUSH;
    end
  end

  // grant strobe doubles as load buffer write
  assign ldbuf_w_o = data_req_o && data_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_ff
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // tag captured at grant, sent in the following cycle
  always_ff @(posedge clk_i) begin : tag_ff
    if (ldbuf_w_o) begin
      tag_q <= ld_req_i.address[`LU_INDEX_W +: `LU_TAG_W];
    end
  end

  assign addr_tag_o = tag_q;

  // --------------------
  // assertions
  // --------------------
  // buffer cannot fill between accept and grant
  gnt_not_full_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
      ldbuf_w_o |-> !ldbuf_full_i)
    else $error("grant taken while load buffer is full");

  // kill only in the tag cycle right after a flush
  kill_in_tag_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
      kill_req_o |-> tag_valid_o && $past(flush_i))
    else $error("kill_req outside of a flush tag cycle");

endmodule

/* logic/load_buffer.sv */
// buffer of outstanding loads
// one slot per request id, retired out of order by cache responses

`timescale 1ns/1ps
`include "load_unit_defines.svh"

module load_buffer (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  // write side, one entry per grant
  input  logic                        ldbuf_w_i,
  input  load_unit_pkg::ldbuf_entry_t wdata_i,
  output logic [`LU_LDBUF_ID_W-1:0]   windex_o,
  output logic                        full_o,
  // response side
  input  logic                        rvalid_i,
  input  logic [`LU_LDBUF_ID_W-1:0]   rid_i,
  output load_unit_pkg::ldbuf_entry_t rdata_o,
  output logic                        rsp_valid_o
);
  import load_unit_pkg::*;

  localparam int unsigned ID_W = `LU_LDBUF_ID_W;

  logic [`LU_NR_LDBUF-1:0] valid_q, valid_d;
  logic [`LU_NR_LDBUF-1:0] flushed_q, flushed_d;
  ldbuf_entry_t entries_q [`LU_NR_LDBUF];
  logic [ID_W-1:0] free_idx;
  logic [ID_W-1:0] last_id_q;
  // high in the kill cycle that follows a flush
  logic flush_q;

  // legal offsets per access size
  function automatic logic offset_ok(ldbuf_entry_t e);
    case (e.operation)
      LD:      return e.address_offset == 3'd0;
      LW, LWU: return e.address_offset[1:0] == 2'd0;
      LH, LHU: return e.address_offset[0] == 1'b0;
      default: return 1'b1;
    endcase
  endfunction

  assign full_o = &valid_q;

  // lowest free slot wins
  always_comb begin : free_search
    free_idx = '0;
    for (int i = `LU_NR_LDBUF - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_idx = ID_W'(i);
      end
    end
  end

  assign windex_o = free_idx;

  // --------------------
  // slot bookkeeping
  // --------------------
  always_comb begin : slot_comb
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // everything in flight is dead after a flush
    if (flush_i) begin
      flushed_d = '1;
    end
    // the load granted together with the flush is killed one cycle later
    if (flush_q) begin
      flushed_d[last_id_q] = 1'b1;
    end
    // retire on response
    if (rvalid_i) begin
      valid_d[rid_i] = 1'b0;
    end
    // new load starts clean
    if (ldbuf_w_i) begin
      valid_d[free_idx]   = 1'b1;
      flushed_d[free_idx] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : slot_ff
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
      last_id_q <= '0;
      flush_q   <= 1'b0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
      flush_q   <= flush_i;
      if (ldbuf_w_i) begin
        last_id_q <= free_idx;
      end
    end
  end

  always_ff @(posedge clk_i) begin : entry_ff
    if (ldbuf_w_i) begin
      entries_q[free_idx] <= wdata_i;
    end
  end

  // --------------------
  // response lookup
  // --------------------
  assign rdata_o = entries_q[rid_i];

  // drop flushed slots and the request killed in this very cycle
  assign rsp_valid_o = rvalid_i && !flushed_q[rid_i] &&
                       !(flush_q && (last_id_q == rid_i));

  // cache answers only ids it was granted
  rsp_slot_valid_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
      rvalid_i |-> valid_q[rid_i])
    else $error("response for a free load buffer slot");

  // LSU hands over naturally aligned loads only
  offset_aligned_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
      ldbuf_w_i |-> offset_ok(wdata_i))
    else $error("misaligned load offset written to buffer");

endmodule

/* logic/load_align.sv */
// load result formatting
// byte shift, optional big-endian swap and sign or zero extension

`timescale 1ns/1ps
`include "load_unit_defines.svh"

module load_align (
  input  logic [`LU_XLEN-1:0]         rdata_i,
  input  load_unit_pkg::ldbuf_entry_t entry_i,
  // big-endian data mode
  input  logic                        mbe_i,
  output logic [`LU_XLEN-1:0]         result_o
);
  import load_unit_pkg::*;

  logic [`LU_XLEN-1:0] shifted_data;
  logic [`LU_XLEN-1:0] endian_data;
  logic is_signed;
  logic msb;
  logic ext_bit;

  // --------------------
  // byte shift
  // --------------------
  // offset selects the first byte of the access within the word
  assign shifted_data = rdata_i >> {entry_i.address_offset, 3'b000};

  // --------------------
  // endian swap
  // --------------------
  // big-endian memory: swap bytes within the access width only
  always_comb begin : endian_swap
    endian_data = shifted_data;
    if (mbe_i) begin
      case (entry_i.operation)
        LW, LWU: begin
          endian_data[31:0] = {<<8{shifted_data[31:0]}};
        end
        LH, LHU: begin
          endian_data[15:0] = {<<8{shifted_data[15:0]}};
        end
        LB, LBU: begin
          // single byte, nothing to swap
          endian_data = shifted_data;
        end
        default: begin
          endian_data = {<<8{shifted_data}};
        end
      endcase
    end
  end

  // --------------------
  // extension
  // --------------------
  assign is_signed = entry_i.operation inside {LW, LH, LB};

  // top bit of the formatted access
  always_comb begin : msb_sel
    case (entry_i.operation)
      LW, LWU: msb = endian_data[31];
      LH, LHU: msb = endian_data[15];
      LB, LBU: msb = endian_data[7];
      default: msb = endian_data[`LU_XLEN-1];
    endcase
  end

  // unsigned loads pull the upper bits to zero
  assign ext_bit = is_signed && msb;

  always_comb begin : result_mux
    case (entry_i.operation)
      LW, LWU: result_o = {{(`LU_XLEN - 32){ext_bit}}, endian_data[31:0]};
      LH, LHU: result_o = {{(`LU_XLEN - 16){ext_bit}}, endian_data[15:0]};
      LB, LBU: result_o = {{(`LU_XLEN - 8){ext_bit}}, endian_data[7:0]};
      // LD uses the full word
      default: result_o = endian_data;
    endcase
  end

endmodule

/* logic/load_unit.sv */
// load unit top
// request FSM, outstanding load buffer and result aligner around the data cache port

`timescale 1ns/1ps
`include "load_unit_defines.svh"

module load_unit (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  // LSU queue
  input  logic                       valid_i,
  input  load_unit_pkg::load_req_t   ld_req_i,
  output logic                       pop_ld_o,
  // store unit page-offset check
  output logic [`LU_INDEX_W-1:0]     page_offset_o,
  input  logic                       page_offset_matches_i,
  // data cache
  output load_unit_pkg::dcache_req_t req_port_o,
  input  load_unit_pkg::dcache_rsp_t req_port_i,
  // big-endian mode
  input  logic                       mbe_i,
  // result to the scoreboard
  output logic                       valid_o,
  output logic [`LU_TRANS_ID_W-1:0]  trans_id_o,
  output logic [`LU_XLEN-1:0]        result_o
);
  import load_unit_pkg::*;

  logic ldbuf_w;
  logic ldbuf_full;
  logic [`LU_LDBUF_ID_W-1:0] ldbuf_windex;
  ldbuf_entry_t ldbuf_wdata;
  ldbuf_entry_t ldbuf_rdata;

  // page offset doubles as cache index
  assign page_offset_o            = ld_req_i.address[`LU_INDEX_W-1:0];
  assign req_port_o.address_index = ld_req_i.address[`LU_INDEX_W-1:0];
  assign req_port_o.data_be       = ld_req_i.be;
  // request id is the buffer slot
  assign req_port_o.data_id       = ldbuf_windex;

  // what the response needs later
  assign ldbuf_wdata.trans_id       = ld_req_i.trans_id;
  assign ldbuf_wdata.address_offset = ld_req_i.address[`LU_OFFSET_W-1:0];
  assign ldbuf_wdata.operation      = ld_req_i.operation;

  load_ctrl_fsm u_ctrl (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .flush_i              (flush_i),
    .valid_i              (valid_i),
    .ld_req_i             (ld_req_i),
    .page_offset_matches_i(page_offset_matches_i),
    .data_gnt_i           (req_port_i.data_gnt),
    .ldbuf_full_i         (ldbuf_full),
    .pop_ld_o             (pop_ld_o),
    .data_req_o           (req_port_o.data_req),
    .tag_valid_o          (req_port_o.tag_valid),
    .kill_req_o           (req_port_o.kill_req),
    .addr_tag_o           (req_port_o.address_tag),
    .data_size_o          (req_port_o.data_size),
    .ldbuf_w_o            (ldbuf_w)
  );

  load_buffer u_ldbuf (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (flush_i),
    .ldbuf_w_i  (ldbuf_w),
    .wdata_i    (ldbuf_wdata),
    .windex_o   (ldbuf_windex),
    .full_o     (ldbuf_full),
    .rvalid_i   (req_port_i.data_rvalid),
    .rid_i      (req_port_i.data_rid),
    .rdata_o    (ldbuf_rdata),
    .rsp_valid_o(valid_o)
  );

  assign trans_id_o = ldbuf_rdata.trans_id;

  load_align u_align (
    .rdata_i (req_port_i.data_rdata),
    .entry_i (ldbuf_rdata),
    .mbe_i   (mbe_i),
    .result_o(result_o)
  );

endmodule

/* bench/dcache_model.sv */
// behavioral data cache for the load unit testbench
// grants at random, answers granted loads out of order with address-derived data

`timescale 1ns/1ps
`include "load_unit_defines.svh"

module dcache_model (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  load_unit_pkg::dcache_req_t req_i,
  // percent chance per cycle
  input  int                         gnt_rate_i,
  input  int                         rsp_rate_i,
  output load_unit_pkg::dcache_rsp_t rsp_o
);
  import load_unit_pkg::*;

  logic gnt_r = 1'b0;
  logic rvalid_r = 1'b0;
  logic [`LU_LDBUF_ID_W-1:0] rid_r = '0;
  logic [`LU_XLEN-1:0] rdata_r = '0;

  // grant waiting for its tag cycle
  logic pend_valid = 1'b0;
  logic [`LU_LDBUF_ID_W-1:0] pend_id = '0;
  logic [`LU_INDEX_W-1:0] pend_index = '0;

  // granted loads with a complete address, not yet answered
  logic [`LU_LDBUF_ID_W-1:0] held_id [$];
  logic [`LU_ADDR_W-1:0] held_addr [$];

  // memory contents, a fixed mix of the word address
  function automatic logic [`LU_XLEN-1:0] word_data(input logic [`LU_ADDR_W-1:0] addr);
    logic [31:0] base;
    base = {addr[31:3], 3'b000};
    return {base[15:0], base[31:16], base[23:0], base[31:24]} ^ 64'h5a3c_96e1_0f87_d2b4;
  endfunction

  assign rsp_o.data_gnt    = gnt_r;
  assign rsp_o.data_rvalid = rvalid_r;
  assign rsp_o.data_rid    = rid_r;
  assign rsp_o.data_rdata  = rdata_r;

  always begin : cache_proc
    int pick;
    // --------------------
    // observe the request port mid-cycle
    // --------------------
    @(negedge clk_i);
    if (rst_ni) begin
      // tag cycle completes the address of the last grant
      if (req_i.tag_valid && pend_valid) begin
        held_id.push_back(pend_id);
        held_addr.push_back({req_i.address_tag, pend_index});
        pend_valid = 1'b0;
      end
      if (req_i.data_req && gnt_r) begin
        pend_valid = 1'b1;
        pend_id    = req_i.data_id;
        pend_index = req_i.address_index;
      end
    end
    // --------------------
    // drive grant and response after the edge
    // --------------------
    @(posedge clk_i);
    #1;
    rvalid_r = 1'b0;
    if (!rst_ni) begin
      gnt_r = 1'b0;
    end else begin
      gnt_r = ($urandom % 100) < 32'(gnt_rate_i);
      // any held load may go next, so answers come out of order
      if (held_id.size() > 0 && ($urandom % 100) < 32'(rsp_rate_i)) begin
        pick     = int'($urandom % 32'(held_id.size()));
        rvalid_r = 1'b1;
        rid_r    = held_id[pick];
        rdata_r  = word_data(held_addr[pick]);
        held_id.delete(pick);
        held_addr.delete(pick);
      end
    end
  end

endmodule

/* bench/tb_load_unit.sv */
// load unit testbench
// random loads against an out-of-order cache model, checked by a slot-based scoreboard

`timescale 1ns/1ps
`include "load_unit_defines.svh"

module tb_load_unit;
  import load_unit_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int LOADS_PER_PHASE = 80;
  localparam int NUM_LOADS = 5 * LOADS_PER_PHASE;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic flush_i;
  logic valid_i;
  load_req_t ld_req_i;
  logic pop_ld_o;
  logic [`LU_INDEX_W-1:0] page_offset_o;
  logic page_offset_matches_i;
  dcache_req_t req_port_o;
  dcache_rsp_t req_port_i;
  logic mbe_i;
  logic valid_o;
  logic [`LU_TRANS_ID_W-1:0] trans_id_o;
  logic [`LU_XLEN-1:0] result_o;

  // stimulus knobs in percent per cycle
  int gnt_rate;
  int rsp_rate;
  int flush_pct;
  logic [`LU_TRANS_ID_W-1:0] next_tid;
  int sent_cnt;
  logic stim_done;

  // scoreboard with one entry per load buffer slot
  logic [`LU_NR_LDBUF-1:0] sb_busy = '0;
  logic [`LU_NR_LDBUF-1:0] sb_flushed = '0;
  load_req_t sb_req [`LU_NR_LDBUF];
  int occupancy = 0;
  logic tag_due = 1'b0;
  logic kill_due = 1'b0;
  logic [`LU_TAG_W-1:0] tag_exp = '0;
  int popped_cnt = 0;
  int answered_cnt = 0;
  int flushed_cnt = 0;
  int full_cycles = 0;
  int check_cnt = 0;
  int err_cnt = 0;

  load_unit dut_i (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .flush_i              (flush_i),
    .valid_i              (valid_i),
    .ld_req_i             (ld_req_i),
    .pop_ld_o             (pop_ld_o),
    .page_offset_o        (page_offset_o),
    .page_offset_matches_i(page_offset_matches_i),
    .req_port_o           (req_port_o),
    .req_port_i           (req_port_i),
    .mbe_i                (mbe_i),
    .valid_o              (valid_o),
    .trans_id_o           (trans_id_o),
    .result_o             (result_o)
  );

  dcache_model cache_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_port_o),
    .gnt_rate_i(gnt_rate),
    .rsp_rate_i(rsp_rate),
    .rsp_o     (req_port_i)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_error(input string msg);
    err_cnt++;
    $display("error at %0t: %s", $time, msg);
  endtask

  function automatic int op_bytes(input load_op_e op);
    case (op)
      LD:      return 8;
      LW, LWU: return 4;
      LH, LHU: return 2;
      default: return 1;
    endcase
  endfunction

  // --------------------
  // reference result
  // --------------------
  // shift to the offset, take the access bytes in memory order, then extend
  function automatic logic [63:0] expected_result(input load_req_t req, input logic big_endian);
    logic [63:0] shifted;
    logic [63:0] val;
    int nb;
    logic negative;
    shifted = cache_i.word_data(req.address) >> (8 * int'(req.address[2:0]));
    nb = op_bytes(req.operation);
    val = '0;
    for (int i = 0; i < nb; i++) begin
      if (big_endian) begin
        val[8*i +: 8] = shifted[8*(nb-1-i) +: 8];
      end else begin
        val[8*i +: 8] = shifted[8*i +: 8];
      end
    end
    negative = val[8*nb-1] && (req.operation inside {LW, LH, LB});
    if (negative) begin
      val = val | ~((64'd1 << (8 * nb)) - 64'd1);
    end
    return val;
  endfunction

  // naturally aligned load of a random size at a random address
  function automatic load_req_t random_load(input logic [`LU_TRANS_ID_W-1:0] tid);
    load_req_t req;
    logic [31:0] addr;
    logic [15:0] mask;
    int nb;
    req.operation = load_op_e'(3'($urandom % 7));
    nb = op_bytes(req.operation);
    addr = $urandom;
    addr[2:0] = addr[2:0] & ~3'(nb - 1);
    mask = (16'd1 << nb) - 16'd1;
    req.trans_id = tid;
    req.address  = addr;
    req.be       = 8'(mask << addr[2:0]);
    return req;
  endfunction

  // --------------------
  // stimulus
  // --------------------
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
    flush_i = ($urandom % 100) < 32'(flush_pct);
  endtask

  // present one load until it is popped, sometimes behind a matching store
  task automatic issue_load();
    int stall;
    logic popped;
    ld_req_i = random_load(next_tid);
    next_tid = next_tid + 1'b1;
    stall = (($urandom % 100) < 25) ? 1 + int'($urandom % 4) : 0;
    valid_i = 1'b1;
    page_offset_matches_i = (stall != 0);
    popped = 1'b0;
    while (!popped) begin
      @(negedge clk_i);
      popped = pop_ld_o;
      next_cycle();
      if (stall > 0) begin
        stall--;
      end
      page_offset_matches_i = (stall != 0);
    end
    valid_i = 1'b0;
    page_offset_matches_i = 1'b0;
    sent_cnt++;
  endtask

  task automatic run_phase(input logic big_endian, input int gnt_pct, input int rsp_pct,
                           input int flush_rate);
    int gap;
    mbe_i = big_endian;
    gnt_rate = gnt_pct;
    rsp_rate = rsp_pct;
    flush_pct = flush_rate;
    for (int n = 0; n < LOADS_PER_PHASE; n++) begin
      issue_load();
      gap = int'($urandom % 3);
      repeat (gap) next_cycle();
    end
    // endian mode only changes with nothing in flight
    flush_pct = 0;
    flush_i = 1'b0;
    while (occupancy != 0) begin
      next_cycle();
    end
    repeat (2) next_cycle();
  endtask

  initial begin : main
    rst_ni = 1'b0;
    flush_i = 1'b0;
    valid_i = 1'b0;
    ld_req_i = '0;
    page_offset_matches_i = 1'b0;
    mbe_i = 1'b0;
    gnt_rate = 0;
    rsp_rate = 0;
    flush_pct = 0;
    next_tid = '0;
    sent_cnt = 0;
    stim_done = 1'b0;
    void'($urandom(32'h52bc));
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    // little-endian, then with flush pulses
    run_phase(1'b0, 60, 50, 0);
    run_phase(1'b0, 60, 50, 4);
    // big-endian
    run_phase(1'b1, 60, 50, 0);
    run_phase(1'b1, 60, 50, 4);
    // rare grants and slow answers keep the buffer full
    run_phase(1'b0, 20, 6, 0);
    stim_done = 1'b1;
  end

  // --------------------
  // monitor and scoreboard
  // --------------------
  // sampled mid-cycle, where inputs and DUT outputs are settled
  always @(negedge clk_i) begin : monitor
    logic [`LU_LDBUF_ID_W-1:0] rid;
    logic [`LU_LDBUF_ID_W-1:0] slot;
    logic [`LU_LDBUF_ID_W-1:0] free_slot;
    logic found;
    logic grant;
    rid = req_port_i.data_rid;
    slot = req_port_o.data_id;
    grant = req_port_o.data_req && req_port_i.data_gnt;
    // lowest slot with no load in flight
    free_slot = '0;
    found = 1'b0;
    for (int i = 0; i < `LU_NR_LDBUF; i++) begin
      if (!found && !sb_busy[i]) begin
        free_slot = `LU_LDBUF_ID_W'(i);
        found = 1'b1;
      end
    end
    if (rst_ni) begin
      // grant or flush is followed by a tag cycle, only the flush kills it
      check_value("req_port_o.tag_valid", 64'(req_port_o.tag_valid),
                  64'(tag_due || kill_due));
      check_value("req_port_o.kill_req", 64'(req_port_o.kill_req), 64'(kill_due));
      if (tag_due) begin
        check_value("req_port_o.address_tag", 64'(req_port_o.address_tag), 64'(tag_exp));
      end
      tag_due = 1'b0;
      kill_due = flush_i;
      check_value("pop_ld_o", 64'(pop_ld_o), 64'(grant));
      check_value("page_offset_o", 64'(page_offset_o),
                  64'(ld_req_i.address[`LU_INDEX_W-1:0]));
      // request fields follow the presented load
      if (req_port_o.data_req) begin
        check_value("req_port_o.address_index", 64'(req_port_o.address_index),
                    64'(ld_req_i.address[`LU_INDEX_W-1:0]));
        check_value("req_port_o.data_be", 64'(req_port_o.data_be), 64'(ld_req_i.be));
        check_value("req_port_o.data_size", 64'(req_port_o.data_size),
                    64'($clog2(op_bytes(ld_req_i.operation))));
      end
      if (page_offset_matches_i && (pop_ld_o || req_port_o.data_req)) begin
        report_error("cache request issued while a store matches the page offset");
      end
      if (occupancy == `LU_NR_LDBUF) begin
        full_cycles++;
        if (pop_ld_o) begin
          report_error("load popped while four loads are unanswered");
        end
      end
      // a response is checked before this cycle's flush marks take effect
      if (req_port_i.data_rvalid) begin
        if (!sb_busy[rid]) begin
          report_error("cache answered a slot with no load in flight");
        end else begin
          check_value("valid_o", 64'(valid_o), 64'(!sb_flushed[rid]));
          if (sb_flushed[rid]) begin
            flushed_cnt++;
          end else if (valid_o) begin
            check_value("trans_id_o", 64'(trans_id_o), 64'(sb_req[rid].trans_id));
            check_value("result_o", result_o, expected_result(sb_req[rid], mbe_i));
          end
          sb_busy[rid] = 1'b0;
          occupancy--;
          answered_cnt++;
        end
      end else if (valid_o) begin
        report_error("valid_o raised without a cache response");
      end
      if (grant) begin
        check_value("req_port_o.data_id", 64'(slot), 64'(free_slot));
        sb_busy[slot] = 1'b1;
        sb_flushed[slot] = 1'b0;
        sb_req[slot] = ld_req_i;
        occupancy++;
        popped_cnt++;
        tag_due = 1'b1;
        tag_exp = ld_req_i.address[`LU_INDEX_W +: `LU_TAG_W];
      end
      // loads popped in the flush cycle are dead too
      if (flush_i) begin
        sb_flushed = sb_flushed | sb_busy;
      end
      if (stim_done) begin
        check_value("outstanding loads", 64'(occupancy), 64'd0);
        check_value("popped loads", 64'(popped_cnt), 64'(sent_cnt));
        if (flushed_cnt == 0) begin
          report_error("no load was ever flushed");
        end
        if (full_cycles == 0) begin
          report_error("the load buffer never filled up");
        end
        $display("loads %0d, answered %0d, flushed %0d, checks %0d, errors %0d",
                 popped_cnt, answered_cnt, flushed_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
          $display("Finished with no errors");
        end else begin
          $display("Finished with errors");
        end
        $finish;
      end
    end
  end

  // budget of 50 cycles per load
  initial begin : watchdog
    #(NUM_LOADS * 50 * CLK_PERIOD);
    $display("timeout: loads did not complete in the expected time");
    $display("Finished with errors");
    $finish;
  end

endmodule

/* tb.f */
+incdir+include
logic/load_unit_pkg.sv
logic/load_ctrl_fsm.sv
logic/load_buffer.sv
logic/load_align.sv
logic/load_unit.sv
bench/dcache_model.sv
bench/tb_load_unit.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the load unit testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f tb.f \
  --top-module tb_load_unit \
  -o sim_load_unit

./obj_dir/sim_load_unit 2>&1 | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation passed"
